// File: axi_lite_pkg.sv
`default_nettype none

// AXI4-Lite bus widths, response codes and front-end FSM states
package axi_lite_pkg;

    localparam int unsigned addr_width = 32;
    localparam int unsigned data_width = 32;
    localparam int unsigned strb_width = data_width / 8;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // one transaction at a time, read or write
    typedef enum logic [2:0] {
        idle,
        read_wait,   // rd_stb issued, waiting on the register answer
        read_resp,
        write_data,  // address taken, waiting on the w channel
        write_wait,
        write_resp
    } axi_state_e;

endpackage

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

    // register map, byte offsets
    localparam int unsigned reg_txdata = 'h0;
    localparam int unsigned reg_status = 'h4;
    localparam int unsigned reg_div    = 'h8;

    // status word bits
    localparam int unsigned stat_full_bit  = 0;
    localparam int unsigned stat_empty_bit = 1;
    localparam int unsigned stat_busy_bit  = 2;  // frame on the line

    localparam int unsigned tx_fifo_depth = 8;

    // one bit lasts div + 1 clocks
    localparam int unsigned div_width = 16;
    localparam int unsigned div_reset = 15;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

endpackage

`default_nettype wire

// File: uart_axi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module uart_axi_slave (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [axi_lite_pkg::addr_width-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,

    output logic [axi_lite_pkg::data_width-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,

    input  logic [axi_lite_pkg::addr_width-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,

    input  logic [axi_lite_pkg::data_width-1:0] wdata,
    input  logic [axi_lite_pkg::strb_width-1:0] wstrb,
    input  logic                                wvalid,
    output logic                                wready,

    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,

    output logic                                rd_stb,
    output logic [axi_lite_pkg::addr_width-1:0] rd_addr,
    output logic                                wr_stb,
    output logic [axi_lite_pkg::addr_width-1:0] wr_addr,
    output logic [axi_lite_pkg::data_width-1:0] wr_data,
    output logic [axi_lite_pkg::strb_width-1:0] wr_strb,
    input  logic [axi_lite_pkg::data_width-1:0] rd_data,
    input  logic                                rd_err,
    input  logic                                wr_err
);
    import axi_lite_pkg::*;

    axi_state_e state;

    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic rd_done;
    logic wr_done;

    assign arready = (state == idle);
    assign awready = (state == idle) && !arvalid;  // a read wins a tie
    assign wready  = (state == write_data);

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // strobe has dropped, so the register answer is already registered
    assign rd_done = (state == read_wait) && !rd_stb;
    assign wr_done = (state == write_wait) && !wr_stb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= idle;
            rd_stb <= 1'b0;
            wr_stb <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            rd_stb <= 1'b0;
            wr_stb <= 1'b0;
            case (state)
                idle: begin
                    if (ar_hs) begin
                        rd_stb <= 1'b1;
                        state  <= read_wait;
                    end else if (aw_hs) begin
                        state <= write_data;
                    end
                end
                read_wait: begin
                    if (rd_done) begin
                        rvalid <= 1'b1;
                        state  <= read_resp;
                    end
                end
                read_resp: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= idle;
                    end
                end
                write_data: begin
                    if (w_hs) begin
                        wr_stb <= 1'b1;
                        state  <= write_wait;
                    end
                end
                write_wait: begin
                    if (wr_done) begin
                        bvalid <= 1'b1;
                        state  <= write_resp;
                    end
                end
                write_resp: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) rd_addr <= araddr;
        if (aw_hs) wr_addr <= awaddr;
        if (w_hs) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
        if (rd_done) begin
            rdata <= rd_data;
            rresp <= rd_err ? resp_slverr : resp_okay;
        end
        if (wr_done) bresp <= wr_err ? resp_slverr : resp_okay;
    end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("read response changed before rready");

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response changed before bready");

    a_one_stb: assert property (@(posedge clk) disable iff (rst)
        !(rd_stb && wr_stb))
        else $error("read and write strobes together");

endmodule

`default_nettype wire

// File: uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rd_stb,
    input  logic [axi_lite_pkg::addr_width-1:0] rd_addr,
    input  logic                                wr_stb,
    input  logic [axi_lite_pkg::addr_width-1:0] wr_addr,
    input  logic [axi_lite_pkg::data_width-1:0] wr_data,
    input  logic [axi_lite_pkg::strb_width-1:0] wr_strb,
    output logic [axi_lite_pkg::data_width-1:0] rd_data,
    output logic                                rd_err,
    output logic                                wr_err,
    output logic                                push,
    output logic [7:0]                          push_data,
    input  logic                                full,
    input  logic                                empty,
    input  logic                                busy,
    output logic [uart_pkg::div_width-1:0]      div
);
    import uart_pkg::*;

    logic wr_txdata;
    logic wr_status;
    logic wr_div;
    logic rd_txdata;
    logic rd_status;
    logic rd_div;
    logic [$bits(rd_data)-1:0] rd_next;

    assign wr_txdata = (wr_addr == reg_txdata);
    assign wr_status = (wr_addr == reg_status);
    assign wr_div    = (wr_addr == reg_div);
    assign rd_txdata = (rd_addr == reg_txdata);
    assign rd_status = (rd_addr == reg_status);
    assign rd_div    = (rd_addr == reg_div);

    // a byte in lane 0 goes to the FIFO unless it is full
    assign push      = wr_stb && wr_txdata && wr_strb[0] && !full;
    assign push_data = wr_data[7:0];

    always_comb begin
        rd_next = '0;  // txdata reads back as zero
        if (rd_status) begin
            rd_next[stat_full_bit]  = full;
            rd_next[stat_empty_bit] = empty;
            rd_next[stat_busy_bit]  = busy;
        end else if (rd_div) begin
            rd_next[div_width-1:0] = div;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_err <= 1'b0;
            wr_err <= 1'b0;
            div    <= div_width'(div_reset);
        end else begin
            if (rd_stb) rd_err <= !(rd_txdata || rd_status || rd_div);
            if (wr_stb) begin
                wr_err <= !(wr_txdata || wr_status || wr_div)
                          || (wr_txdata && wr_strb[0] && full);  // byte dropped
                if (wr_div && wr_strb[0]) div[7:0] <= wr_data[7:0];
                if (wr_div && wr_strb[1]) div[div_width-1:8] <= wr_data[div_width-1:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stb) rd_data <= rd_next;
    end

    a_stb_pulse: assert property (@(posedge clk) disable iff (rst)
        (rd_stb || wr_stb) |=> !(rd_stb || wr_stb))
        else $error("register strobe high for more than one cycle");

endmodule

`default_nettype wire

// File: uart_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo #(
    parameter int unsigned depth = uart_pkg::tx_fifo_depth
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);
    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    logic [7:0]       mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // wraps for any depth, not only powers of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == cnt_w'(depth));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];  // head byte

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("pop from empty FIFO");

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push into full FIFO");

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [uart_pkg::div_width-1:0] div,
    input  logic                           empty,
    input  logic [7:0]                     pop_data,
    output logic                           pop,
    output logic                           busy,
    output logic                           tx
);
    import uart_pkg::*;

    tx_state_e            state;
    logic [div_width-1:0] div_q;    // divisor held for the whole frame
    logic [div_width-1:0] bit_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift;
    logic                 bit_done;

    assign pop      = (state == tx_idle) && !empty;
    assign busy     = (state != tx_idle);
    assign bit_done = (bit_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= tx_idle;
            tx      <= 1'b1;
            div_q   <= div_width'(div_reset);
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            if (state != tx_idle && !bit_done) bit_cnt <= bit_cnt - 1'b1;
            case (state)
                tx_idle: begin
                    if (pop) begin
                        state   <= tx_start;
                        tx      <= 1'b0;  // start bit
                        div_q   <= div;
                        bit_cnt <= div;
                    end
                end
                tx_start: begin
                    if (bit_done) begin
                        state   <= tx_data;
                        tx      <= shift[0];
                        bit_idx <= '0;
                        bit_cnt <= div_q;
                    end
                end
                tx_data: begin
                    if (bit_done) begin
                        bit_cnt <= div_q;
                        if (bit_idx == 3'd7) begin
                            state <= tx_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift[1];  // next bit, LSB first
                        end
                    end
                end
                tx_stop: begin
                    if (bit_done) state <= tx_idle;
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) shift <= pop_data;
        else if (state == tx_data && bit_done) shift <= shift >> 1;
    end

endmodule

`default_nettype wire

// File: uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [axi_lite_pkg::addr_width-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [axi_lite_pkg::data_width-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,

    input  logic [axi_lite_pkg::addr_width-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi_lite_pkg::data_width-1:0] wdata,
    input  logic [axi_lite_pkg::strb_width-1:0] wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,

    output logic                                tx
);
    import uart_pkg::*;

    logic                                rd_stb;
    logic [axi_lite_pkg::addr_width-1:0] rd_addr;
    logic                                wr_stb;
    logic [axi_lite_pkg::addr_width-1:0] wr_addr;
    logic [axi_lite_pkg::data_width-1:0] wr_data;
    logic [axi_lite_pkg::strb_width-1:0] wr_strb;
    logic [axi_lite_pkg::data_width-1:0] rd_data;
    logic                                rd_err;
    logic                                wr_err;
    logic                                push;
    logic [7:0]                          push_data;
    logic                                pop;
    logic [7:0]                          pop_data;
    logic                                full;
    logic                                empty;
    logic                                busy;
    logic [div_width-1:0]                div;

    uart_axi_slave u_axi_slave (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .rd_stb  (rd_stb),
        .rd_addr (rd_addr),
        .wr_stb  (wr_stb),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .rd_data (rd_data),
        .rd_err  (rd_err),
        .wr_err  (wr_err)
    );

    uart_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .rd_stb    (rd_stb),
        .rd_addr   (rd_addr),
        .wr_stb    (wr_stb),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_strb   (wr_strb),
        .rd_data   (rd_data),
        .rd_err    (rd_err),
        .wr_err    (wr_err),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .empty     (empty),
        .busy      (busy),
        .div       (div)
    );

    uart_tx_fifo #(
        .depth (tx_fifo_depth)
    ) u_tx_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .div      (div),
        .empty    (empty),
        .pop_data (pop_data),
        .pop      (pop),
        .busy     (busy),
        .tx       (tx)
    );

endmodule

`default_nettype wire

// File: tb_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;
    import axi_lite_pkg::*;
    import uart_pkg::*;

    localparam int hs_timeout = 100;  // cycles per bus handshake

    logic                  clk;
    logic                  rst;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [data_width-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic                  tx;

    // model state
    logic [15:0] model_div = div_reset;
    int          mon_div = div_reset;  // divisor the line monitor uses
    int          queued;               // bytes accepted since the line was last idle
    int          sent_total;
    int          rx_total;
    int          err_count;
    int          xfer_count;
    logic [7:0]  sent_q[$];
    logic [7:0]  rx_q[$];

    uart_top u_uart_top (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected {resp, rdata}, status reads are only made with the line idle
    function automatic logic [33:0] reg_model(input logic is_write, input logic [31:0] offset,
                                              input logic [15:0] mdiv, input int level,
                                              input logic [3:0] strb);
        logic [31:0] data;
        logic [1:0]  resp;
        data = '0;
        resp = resp_okay;
        case (offset)
            reg_txdata: if (is_write && strb[0] && level >= tx_fifo_depth) resp = resp_slverr;
            reg_status: begin
                data[stat_full_bit]  = (level >= tx_fifo_depth);
                data[stat_empty_bit] = (level == 0);
            end
            reg_div: data[15:0] = mdiv;
            default: resp = resp_slverr;
        endcase
        if (is_write) data = '0;
        return {resp, data};
    endfunction

    // the first byte of a burst goes straight into the serializer
    function automatic int fifo_level();
        return (queued == 0) ? 0 : queued - 1;
    endfunction

    task automatic report_error(input string msg);
        err_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: %s did not happen", $time, what);
        $display("transactions: %0d, bytes: %0d, errors: %0d", xfer_count, rx_total, err_count);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold, output logic [1:0] resp);
        int cnt;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        cnt = 0;
        while (!awready) begin
            next_cycle();
            cnt++;
            if (cnt > hs_timeout) abort_on_timeout("aw handshake");
        end
        next_cycle();  // address taken on this edge
        awvalid = 1'b0;
        cnt = 0;
        while (!wready) begin
            next_cycle();
            cnt++;
            if (cnt > hs_timeout) abort_on_timeout("w handshake");
        end
        next_cycle();
        wvalid = 1'b0;
        cnt = 0;
        while (!bvalid) begin
            next_cycle();
            cnt++;
            if (cnt > hs_timeout) abort_on_timeout("bvalid");
        end
        if (cnt != 2) report_error($sformatf("bvalid %0d cycles after w, expected 2", cnt));
        resp = bresp;
        repeat (hold) begin
            next_cycle();
            if (bvalid !== 1'b1 || bresp !== resp) report_error("write response not held");
            if (awready !== 1'b0) report_error("awready high while response pending");
        end
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
        xfer_count++;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int cnt;
        araddr  = addr;
        arvalid = 1'b1;
        cnt = 0;
        while (!arready) begin
            next_cycle();
            cnt++;
            if (cnt > hs_timeout) abort_on_timeout("ar handshake");
        end
        next_cycle();
        arvalid = 1'b0;
        cnt = 0;
        while (!rvalid) begin
            next_cycle();
            cnt++;
            if (cnt > hs_timeout) abort_on_timeout("rvalid");
        end
        if (cnt != 2) report_error($sformatf("rvalid %0d cycles after ar, expected 2", cnt));
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            next_cycle();
            if (rvalid !== 1'b1 || rdata !== data || rresp !== resp)
                report_error("read response not held");
            if (arready !== 1'b0) report_error("arready high while response pending");
        end
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
        xfer_count++;
    endtask

    task automatic write_check(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input int hold);
        logic [33:0] exp;
        logic [1:0]  resp;
        exp = reg_model(1'b1, addr, model_div, fifo_level(), strb);
        axi_write(addr, data, strb, hold, resp);
        if (resp !== exp[33:32])
            report_error($sformatf("write 0x%0h: bresp %0d, expected %0d", addr, resp, exp[33:32]));
        if (exp[33:32] == resp_okay && addr == reg_div) begin
            if (strb[0]) model_div[7:0] = data[7:0];
            if (strb[1]) model_div[15:8] = data[15:8];
            mon_div = model_div;  // line is idle whenever the divisor changes
        end
        if (exp[33:32] == resp_okay && addr == reg_txdata && strb[0]) begin
            sent_q.push_back(data[7:0]);
            queued++;
            sent_total++;
        end
    endtask

    task automatic read_check(input logic [31:0] addr, input int hold);
        logic [33:0] exp;
        logic [31:0] data;
        logic [1:0]  resp;
        exp = reg_model(1'b0, addr, model_div, fifo_level(), 4'h0);
        axi_read(addr, hold, data, resp);
        if (resp !== exp[33:32])
            report_error($sformatf("read 0x%0h: rresp %0d, expected %0d", addr, resp, exp[33:32]));
        else if (resp == resp_okay && data !== exp[31:0])
            report_error($sformatf("read 0x%0h: 0x%0h, expected 0x%0h", addr, data, exp[31:0]));
    endtask

    // all bytes decoded, then poll status until the frame is over
    task automatic wait_line_done(input int max_cycles);
        int          cnt;
        logic [31:0] data;
        logic [1:0]  resp;
        cnt = 0;
        while (rx_total < sent_total) begin
            next_cycle();
            cnt++;
            if (cnt > max_cycles) abort_on_timeout("serial bytes on tx");
        end
        cnt = 0;
        data = 32'hffff_ffff;
        while (data[stat_busy_bit] !== 1'b0) begin
            axi_read(reg_status, 0, data, resp);
            cnt++;
            if (cnt > 1000) abort_on_timeout("serializer idle");
        end
        queued = 0;
        read_check(reg_status, 0);
    endtask

    // samples tx at mid-bit
    initial begin : line_monitor
        int         bit_clks;
        logic [7:0] data;
        forever begin
            @(negedge clk);
            if (!rst && tx === 1'b0) begin
                bit_clks = mon_div + 1;
                repeat (bit_clks / 2 - 1) @(negedge clk);
                if (tx !== 1'b0) report_error("start bit ended early");
                for (int i = 0; i < 8; i++) begin
                    repeat (bit_clks) @(negedge clk);
                    data[i] = tx;  // LSB first
                end
                repeat (bit_clks) @(negedge clk);
                if (tx !== 1'b1) report_error("stop bit missing");
                rx_q.push_back(data);
                rx_total++;
            end
        end
    end

    initial begin : byte_compare
        logic [7:0] got;
        logic [7:0] exp;
        forever begin
            @(posedge clk);
            if (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                if (sent_q.size() == 0) begin
                    report_error($sformatf("byte 0x%02h on tx was never sent", got));
                end else begin
                    exp = sent_q.pop_front();
                    if (got !== exp) report_error($sformatf("tx byte 0x%02h, expected 0x%02h", got, exp));
                end
            end
        end
    end

    initial begin
        logic [31:0] v;
        void'($urandom(32'hbb84));
        rst     = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset state
        if (tx !== 1'b1 || arready !== 1'b1 || awready !== 1'b1)
            report_error("tx, arready or awready not high after reset");
        if (wready !== 1'b0 || rvalid !== 1'b0 || bvalid !== 1'b0)
            report_error("wready, rvalid or bvalid not low after reset");
        read_check(reg_status, 0);

        // divisor
        read_check(reg_div, 0);
        repeat (4) begin
            v = $urandom_range(1, 40);
            write_check(reg_div, v, 4'b0011, 0);
            read_check(reg_div, 0);
        end

        // transmit
        write_check(reg_div, $urandom_range(2, 6), 4'b0011, 0);
        repeat (6) write_check(reg_txdata, $urandom(), 4'b0001, 0);
        wait_line_done(5000);

        // strobes and errors
        write_check(reg_txdata, 32'h5a, 4'b1110, 0);
        read_check(reg_status, 0);
        write_check(32'h10, 32'h1234, 4'hf, 0);
        read_check(32'h10, 0);
        read_check(32'hc, 0);
        write_check(reg_status, 32'hffff_ffff, 4'hf, 0);
        read_check(reg_txdata, 0);

        // overflow with a slow line
        write_check(reg_div, 1000, 4'b0011, 0);
        repeat (tx_fifo_depth + 2) write_check(reg_txdata, $urandom(), 4'b0001, 0);
        wait_line_done(150000);

        // back-pressure
        write_check(reg_div, 4, 4'b0011, 0);
        read_check(reg_div, $urandom_range(2, 9));
        write_check(reg_div, $urandom_range(1, 40), 4'b0011, $urandom_range(2, 9));
        read_check(reg_status, $urandom_range(2, 9));
        read_check(32'h10, $urandom_range(2, 9));
        write_check(32'h14, 32'h0, 4'hf, $urandom_range(2, 9));

        repeat (3) next_cycle();
        if (sent_q.size() != 0) begin
            err_count++;
            $display("%0d accepted bytes never appeared on tx", sent_q.size());
        end
        $display("transactions: %0d, bytes: %0d, errors: %0d", xfer_count, rx_total, err_count);
        if (err_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
axi_lite_pkg.sv
uart_pkg.sv
uart_axi_slave.sv
uart_regs.sv
uart_tx_fifo.sv
uart_tx.sv
uart_top.sv
tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_axi_tx

sources:
  - axi_lite_pkg.sv
  - uart_pkg.sv
  - uart_axi_slave.sv
  - uart_regs.sv
  - uart_tx_fifo.sv
  - uart_tx.sv
  - uart_top.sv
  - target: test
    files:
      - tb_uart_top.sv
